// File: mm_ram_pkg.sv
// mm_ram shared types, peripheral address map and debug command layout
`default_nettype none

package mm_ram_pkg;

    // --------------------
    // word types
    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;
    typedef logic [31:0] irq_vec_t;
    typedef logic [4:0]  irq_id_t;

    // one data bus request, core side or decoded RAM side
    typedef struct packed {
        word_t addr;
        logic  we;
        be_t   be;
        word_t wdata;
    } data_req_t;

    // debug control word, msb first
    typedef struct packed {
        logic        level_value;  // value driven on debug_req
        logic        pulse_mode;   // 0 level, 1 pulse
        logic        rand_dur;     // not supported
        logic [12:0] duration;
        logic        rand_start;   // not supported
        logic [14:0] delay;
    } dbg_cmd_t;

    // data read source
    typedef enum logic {SEL_RAM, SEL_ZERO} rdata_sel_e;

    // debug request generator states
    typedef enum logic [1:0] {DBG_IDLE, DBG_DELAY, DBG_PULSE} dbg_state_e;

    // --------------------
    // pseudo peripheral map
    localparam word_t ADDR_TEST_STATUS = 32'h2000_0000;
    localparam word_t ADDR_EXIT        = 32'h2000_0004;
    localparam word_t ADDR_TIMER_MASK  = 32'h1500_0000;
    localparam word_t ADDR_TIMER_COUNT = 32'h1500_0004;
    localparam word_t ADDR_DEBUG_CTRL  = 32'h1500_0008;

    // status codes written by the test program
    localparam word_t TEST_PASS_CODE = 32'd123456789;
    localparam word_t TEST_FAIL_CODE = 32'd1;

endpackage

`default_nettype wire

// File: mm_ram_dp_ram.sv
// dual-port byte RAM with a wide instruction read port and a byte-enabled data port
`timescale 1ns/1ps
`default_nettype none

module mm_ram_dp_ram #(
    parameter int RAM_ADDR_WIDTH    = 16,
    parameter int INSTR_RDATA_WIDTH = 128
) (
    input  wire logic                          clk_i,
    input  wire logic                          instr_en_i,
    input  wire logic [RAM_ADDR_WIDTH-1:0]     instr_addr_i,
    output logic      [INSTR_RDATA_WIDTH-1:0]  instr_rdata_o,
    input  wire logic                          data_en_i,
    input  wire mm_ram_pkg::data_req_t         data_i,
    output mm_ram_pkg::word_t                  data_rdata_o
);

    localparam int INSTR_BYTES = INSTR_RDATA_WIDTH / 8;

    // byte storage, no reset
    logic [7:0] mem [2**RAM_ADDR_WIDTH];

    logic [RAM_ADDR_WIDTH-1:0] instr_base;
    logic [RAM_ADDR_WIDTH-1:0] data_base;

    // both ports word aligned
    assign instr_base = {instr_addr_i[RAM_ADDR_WIDTH-1:2], 2'b00};
    assign data_base  = {data_i.addr[RAM_ADDR_WIDTH-1:2], 2'b00};

    // --------------------
    // instruction port, lowest byte first, wraps at top of RAM
    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            for (int i = 0; i < INSTR_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_base + RAM_ADDR_WIDTH'(i)];
            end
        end
    end

    // --------------------
    // data port
    // read returns the old content on a write
    always_ff @(posedge clk_i) begin
        if (data_en_i) begin
            for (int i = 0; i < 4; i++) begin
                data_rdata_o[8*i +: 8] <= mem[data_base + RAM_ADDR_WIDTH'(i)];
                if (data_i.we && data_i.be[i]) begin
                    mem[data_base + RAM_ADDR_WIDTH'(i)] <= data_i.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: mm_ram_addr_decode.sv
// data bus decoder, RAM range and debug window remap, peripheral write strobes
`timescale 1ns/1ps
`default_nettype none

module mm_ram_addr_decode #(
    parameter int RAM_ADDR_WIDTH = 16,
    parameter int DBG_ADDR_WIDTH = 14
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic                   data_req_i,
    input  wire mm_ram_pkg::data_req_t  data_i,
    input  wire mm_ram_pkg::word_t      dm_halt_addr_i,
    output logic                        ram_req_o,
    output mm_ram_pkg::data_req_t       ram_o,
    output logic                        status_we_o,
    output logic                        exit_we_o,
    output logic                        mask_we_o,
    output logic                        count_we_o,
    output logic                        cmd_we_o,
    output mm_ram_pkg::rdata_sel_e      rdata_sel_o
);

    // RAM size and start of the debug code area at its top
    localparam mm_ram_pkg::word_t RAM_SIZE = mm_ram_pkg::word_t'(1) << RAM_ADDR_WIDTH;
    localparam mm_ram_pkg::word_t DBG_SIZE = mm_ram_pkg::word_t'(1) << DBG_ADDR_WIDTH;
    localparam mm_ram_pkg::word_t DBG_BASE = RAM_SIZE - DBG_SIZE;

    mm_ram_pkg::word_t      dbg_offset;
    logic                   in_dbg;
    logic                   in_ram;
    logic                   mapped;
    logic                   periph_we;
    mm_ram_pkg::rdata_sel_e rdata_sel_d;

    // --------------------
    // range checks
    // offset compare avoids overflow of halt addr + window size
    assign dbg_offset = data_i.addr - dm_halt_addr_i;
    assign in_dbg     = (data_i.addr >= dm_halt_addr_i) && (dbg_offset < DBG_SIZE);
    assign in_ram     = data_i.addr < RAM_SIZE;
    assign mapped     = in_dbg || in_ram;

    // decoded request into RAM
    always_comb begin
        ram_o = data_i;
        // debug window wins over the plain RAM range
        if (in_dbg) begin
            ram_o.addr = dbg_offset + DBG_BASE;
        end
    end

    assign ram_req_o = data_req_i && mapped;

    // --------------------
    // peripheral write strobes, single cycle
    assign periph_we   = data_req_i && data_i.we && !mapped;
    assign status_we_o = periph_we && (data_i.addr == mm_ram_pkg::ADDR_TEST_STATUS);
    assign exit_we_o   = periph_we && (data_i.addr == mm_ram_pkg::ADDR_EXIT);
    assign mask_we_o   = periph_we && (data_i.addr == mm_ram_pkg::ADDR_TIMER_MASK);
    assign count_we_o  = periph_we && (data_i.addr == mm_ram_pkg::ADDR_TIMER_COUNT);
    assign cmd_we_o    = periph_we && (data_i.addr == mm_ram_pkg::ADDR_DEBUG_CTRL);

    // --------------------
    // read source
    // unmapped or peripheral reads give zero
    always_comb begin
        rdata_sel_d = mm_ram_pkg::SEL_RAM;
        if (data_req_i && !data_i.we && !mapped) begin
            rdata_sel_d = mm_ram_pkg::SEL_ZERO;
        end
    end

    // lines up with data rvalid
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_sel_o <= mm_ram_pkg::SEL_RAM;
        end else begin
            rdata_sel_o <= rdata_sel_d;
        end
    end

endmodule

`default_nettype wire

// File: mm_ram_status.sv
// test status block, pass/fail pulses and exit value register
`timescale 1ns/1ps
`default_nettype none

module mm_ram_status (
    input  wire logic               clk_i,
    input  wire logic               rst_ni,
    input  wire logic               status_we_i,
    input  wire logic               exit_we_i,
    input  wire mm_ram_pkg::word_t  wdata_i,
    output logic                    tests_passed_o,
    output logic                    tests_failed_o,
    output logic                    exit_valid_o,
    output mm_ram_pkg::word_t       exit_value_o
);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else begin
            // pulses last one cycle
            // any other status code raises neither
            tests_passed_o <= status_we_i && (wdata_i == mm_ram_pkg::TEST_PASS_CODE);
            tests_failed_o <= status_we_i && (wdata_i == mm_ram_pkg::TEST_FAIL_CODE);
            exit_valid_o   <= exit_we_i;
            // exit value holds until next exit write
            if (exit_we_i) begin
                exit_value_o <= wdata_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: mm_ram_irq_timer.sv
// countdown timer that loads a masked interrupt vector, cleared per bit on acknowledge
`timescale 1ns/1ps
`default_nettype none

module mm_ram_irq_timer (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 mask_we_i,
    input  wire logic                 count_we_i,
    input  wire mm_ram_pkg::word_t    wdata_i,
    input  wire logic                 irq_ack_i,
    input  wire mm_ram_pkg::irq_id_t  irq_id_i,
    output mm_ram_pkg::irq_vec_t      irq_o
);

    mm_ram_pkg::irq_vec_t mask_q;
    mm_ram_pkg::word_t    count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q  <= '0;
            count_q <= '0;
            irq_o   <= '0;
        end else begin
            if (mask_we_i) begin
                mask_q <= wdata_i;
            end

            // --------------------
            // counter, stops at zero
            if (count_we_i) begin
                count_q <= wdata_i;
            end else if (count_q != '0) begin
                count_q <= count_q - 1'b1;
            end

            // fire on the last count, v edges after the write
            // firing wins over a same-edge ack
            if (count_q == 32'd1) begin
                irq_o <= mask_q;
            end else if (irq_ack_i) begin
                irq_o[irq_id_i] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: mm_ram_debug_req.sv
// debug request generator, delay then level or delay then pulse
`timescale 1ns/1ps
`default_nettype none

module mm_ram_debug_req (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  cmd_we_i,
    input  wire mm_ram_pkg::dbg_cmd_t  cmd_i,
    output logic                       debug_req_o
);

    mm_ram_pkg::dbg_state_e state_q;

    // counters sized to the command fields
    logic [14:0] delay_q;
    logic [12:0] dur_q;
    logic        level_q;
    logic        pulse_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= mm_ram_pkg::DBG_IDLE;
            delay_q     <= '0;
            dur_q       <= '0;
            level_q     <= 1'b0;
            pulse_q     <= 1'b0;
            debug_req_o <= 1'b0;
        end else begin
            case (state_q)
                // --------------------
                // take a command, only here
                mm_ram_pkg::DBG_IDLE: begin
                    if (cmd_we_i) begin
                        // zero fields count as one
                        delay_q <= (cmd_i.delay == '0) ? 15'd1 : cmd_i.delay;
                        dur_q   <= (cmd_i.duration == '0) ? 13'd1 : cmd_i.duration;
                        level_q <= cmd_i.level_value;
                        pulse_q <= cmd_i.pulse_mode;
                        state_q <= mm_ram_pkg::DBG_DELAY;
                    end
                end
                // start delay, apply value on the last count
                mm_ram_pkg::DBG_DELAY: begin
                    if (delay_q == 15'd1) begin
                        debug_req_o <= level_q;
                        state_q     <= pulse_q ? mm_ram_pkg::DBG_PULSE : mm_ram_pkg::DBG_IDLE;
                    end else begin
                        delay_q <= delay_q - 15'd1;
                    end
                end
                // pulse width, then drop back to the inverse
                mm_ram_pkg::DBG_PULSE: begin
                    if (dur_q == 13'd1) begin
                        debug_req_o <= ~level_q;
                        state_q     <= mm_ram_pkg::DBG_IDLE;
                    end else begin
                        dur_q <= dur_q - 13'd1;
                    end
                end
                default: state_q <= mm_ram_pkg::DBG_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: mm_ram.sv
// mm_ram top, RAM and pseudo peripherals on a core's instruction and data buses
`timescale 1ns/1ps
`default_nettype none

module mm_ram #(
    parameter int RAM_ADDR_WIDTH    = 16,
    parameter int INSTR_RDATA_WIDTH = 128,
    parameter int DBG_ADDR_WIDTH    = 14
) (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire mm_ram_pkg::word_t            dm_halt_addr_i,
    // instruction bus
    input  wire logic                         instr_req_i,
    input  wire mm_ram_pkg::word_t            instr_addr_i,
    output logic                              instr_gnt_o,
    output logic                              instr_rvalid_o,
    output logic      [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,
    // data bus
    input  wire logic                         data_req_i,
    input  wire mm_ram_pkg::data_req_t        data_i,
    output logic                              data_gnt_o,
    output logic                              data_rvalid_o,
    output mm_ram_pkg::word_t                 data_rdata_o,
    // interrupts and debug
    input  wire logic                         irq_ack_i,
    input  wire mm_ram_pkg::irq_id_t          irq_id_i,
    output mm_ram_pkg::irq_vec_t              irq_o,
    output logic                              debug_req_o,
    // test status
    output logic                              tests_passed_o,
    output logic                              tests_failed_o,
    output logic                              exit_valid_o,
    output mm_ram_pkg::word_t                 exit_value_o
);

    localparam mm_ram_pkg::word_t RAM_SIZE = mm_ram_pkg::word_t'(1) << RAM_ADDR_WIDTH;
    localparam mm_ram_pkg::word_t DBG_SIZE = mm_ram_pkg::word_t'(1) << DBG_ADDR_WIDTH;
    localparam mm_ram_pkg::word_t DBG_BASE = RAM_SIZE - DBG_SIZE;

    mm_ram_pkg::word_t         instr_offset;
    logic                      instr_in_dbg;
    logic [RAM_ADDR_WIDTH-1:0] instr_ram_addr;

    logic                   ram_req;
    mm_ram_pkg::data_req_t  ram_data;
    mm_ram_pkg::word_t      ram_rdata;
    mm_ram_pkg::rdata_sel_e rdata_sel;
    logic                   status_we;
    logic                   exit_we;
    logic                   mask_we;
    logic                   count_we;
    logic                   cmd_we;

    // --------------------
    // handshake, no stalls
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    // rvalid one cycle after every request, writes too
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
        end
    end

    // --------------------
    // fetches from the debug window come from the top of RAM
    assign instr_offset   = instr_addr_i - dm_halt_addr_i;
    assign instr_in_dbg   = (instr_addr_i >= dm_halt_addr_i) && (instr_offset < DBG_SIZE);
    assign instr_ram_addr = instr_in_dbg ? RAM_ADDR_WIDTH'(instr_offset + DBG_BASE)
                                         : instr_addr_i[RAM_ADDR_WIDTH-1:0];

    mm_ram_addr_decode #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .DBG_ADDR_WIDTH (DBG_ADDR_WIDTH)
    ) u_decode (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .data_i         (data_i),
        .dm_halt_addr_i (dm_halt_addr_i),
        .ram_req_o      (ram_req),
        .ram_o          (ram_data),
        .status_we_o    (status_we),
        .exit_we_o      (exit_we),
        .mask_we_o      (mask_we),
        .count_we_o     (count_we),
        .cmd_we_o       (cmd_we),
        .rdata_sel_o    (rdata_sel)
    );

    mm_ram_dp_ram #(
        .RAM_ADDR_WIDTH    (RAM_ADDR_WIDTH),
        .INSTR_RDATA_WIDTH (INSTR_RDATA_WIDTH)
    ) u_ram (
        .clk_i         (clk_i),
        .instr_en_i    (instr_req_i),
        .instr_addr_i  (instr_ram_addr),
        .instr_rdata_o (instr_rdata_o),
        .data_en_i     (ram_req),
        .data_i        (ram_data),
        .data_rdata_o  (ram_rdata)
    );

    // zero for unmapped reads
    assign data_rdata_o = (rdata_sel == mm_ram_pkg::SEL_RAM) ? ram_rdata : '0;

    // --------------------
    // pseudo peripherals, write data straight from the bus
    mm_ram_status u_status (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .status_we_i    (status_we),
        .exit_we_i      (exit_we),
        .wdata_i        (data_i.wdata),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    mm_ram_irq_timer u_timer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .mask_we_i  (mask_we),
        .count_we_i (count_we),
        .wdata_i    (data_i.wdata),
        .irq_ack_i  (irq_ack_i),
        .irq_id_i   (irq_id_i),
        .irq_o      (irq_o)
    );

    mm_ram_debug_req u_debug (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cmd_we_i    (cmd_we),
        .cmd_i       (mm_ram_pkg::dbg_cmd_t'(data_i.wdata)),
        .debug_req_o (debug_req_o)
    );

endmodule

`default_nettype wire

// File: mm_ram_tb.sv
// mm_ram testbench driving random bus traffic against a RAM and peripheral model
`timescale 1ns/1ps
`default_nettype none

module mm_ram_tb;

    localparam int RAM_AW     = 16;
    localparam int INSTR_W    = 128;
    localparam int DBG_AW     = 14;
    localparam int RAM_BYTES  = 2**RAM_AW;
    localparam int DBG_LOW    = 2**RAM_AW - 2**DBG_AW;
    localparam int FILL_WORDS = 64;
    localparam int WAIT_LIMIT = 16;

    logic                  clk_i;
    logic                  rst_ni;
    mm_ram_pkg::word_t     dm_halt_addr_i;
    logic                  instr_req_i;
    mm_ram_pkg::word_t     instr_addr_i;
    logic                  instr_gnt_o;
    logic                  instr_rvalid_o;
    logic [INSTR_W-1:0]    instr_rdata_o;
    logic                  data_req_i;
    mm_ram_pkg::data_req_t data_i;
    logic                  data_gnt_o;
    logic                  data_rvalid_o;
    mm_ram_pkg::word_t     data_rdata_o;
    logic                  irq_ack_i;
    mm_ram_pkg::irq_id_t   irq_id_i;
    mm_ram_pkg::irq_vec_t  irq_o;
    logic                  debug_req_o;
    logic                  tests_passed_o;
    logic                  tests_failed_o;
    logic                  exit_valid_o;
    mm_ram_pkg::word_t     exit_value_o;

    // --------------------
    // model state
    logic [7:0]           model_mem [RAM_BYTES];
    mm_ram_pkg::irq_vec_t model_irq;
    logic                 model_dbg;
    int                   errors;
    int                   tests_run;
    int                   tests_failed;

    mm_ram #(
        .RAM_ADDR_WIDTH    (RAM_AW),
        .INSTR_RDATA_WIDTH (INSTR_W),
        .DBG_ADDR_WIDTH    (DBG_AW)
    ) uut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dm_halt_addr_i (dm_halt_addr_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_i         (data_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_o          (irq_o),
        .debug_req_o    (debug_req_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // --------------------
    // error lines and per-test summary
    task automatic fail_value(input string name, input logic [INSTR_W-1:0] got,
                              input logic [INSTR_W-1:0] exp);
        errors++;
        $display("Fail %s: got %0h, expected %0h", name, got, exp);
    endtask

    task automatic fail_text(input string msg);
        errors++;
        $display("Error %s", msg);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    // --------------------
    // reference address map
    // returns -1 when unmapped
    function automatic int ram_index(input mm_ram_pkg::word_t addr);
        longint a;
        longint h;
        a = addr;
        h = dm_halt_addr_i;
        // debug window first
        // it lands at the top of RAM
        if (a >= h && a < h + (longint'(1) << DBG_AW)) begin
            return int'(a - h) + DBG_LOW;
        end
        if (a < RAM_BYTES) begin
            return int'(a);
        end
        return -1;
    endfunction

    function automatic void model_write(input mm_ram_pkg::word_t addr, input mm_ram_pkg::be_t be,
                                        input mm_ram_pkg::word_t wdata);
        int idx;
        idx = ram_index(addr);
        // unmapped writes vanish
        if (idx < 0) begin
            return;
        end
        idx = idx & ~3;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                model_mem[idx + i] = wdata[8*i +: 8];
            end
        end
    endfunction

    function automatic mm_ram_pkg::word_t model_read(input mm_ram_pkg::word_t addr);
        int                idx;
        mm_ram_pkg::word_t word;
        idx = ram_index(addr);
        if (idx < 0) begin
            return '0;
        end
        idx = idx & ~3;
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = model_mem[idx + i];
        end
        return word;
    endfunction

    // wide fetch with the lowest byte first
    function automatic logic [INSTR_W-1:0] model_fetch(input mm_ram_pkg::word_t addr);
        logic [INSTR_W-1:0] line;
        int                 idx;
        idx = ram_index(addr) & ~3;
        for (int i = 0; i < INSTR_W / 8; i++) begin
            line[8*i +: 8] = model_mem[(idx + i) % RAM_BYTES];
        end
        return line;
    endfunction

    // --------------------
    // data bus access started on a falling edge
    // returns on the falling edge after the response
    task automatic bus_access(input mm_ram_pkg::word_t addr, input logic we,
                              input mm_ram_pkg::be_t be, input mm_ram_pkg::word_t wdata,
                              output mm_ram_pkg::word_t rdata);
        int cycles;
        data_req_i   = 1'b1;
        data_i.addr  = addr;
        data_i.we    = we;
        data_i.be    = be;
        data_i.wdata = wdata;
        @(posedge clk_i);
        if (data_gnt_o !== 1'b1)
            fail_value("data_gnt_o", data_gnt_o, 1);
        @(negedge clk_i);
        data_req_i = 1'b0;
        data_i     = '0;
        cycles     = 1;
        while (data_rvalid_o !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (data_rvalid_o !== 1'b1)
            fail_text("timeout waiting for data_rvalid_o");
        else if (cycles != 1)
            fail_value("data_rvalid_o latency", cycles, 1);
        rdata = data_rdata_o;
    endtask

    task automatic write_word(input mm_ram_pkg::word_t addr, input mm_ram_pkg::be_t be,
                              input mm_ram_pkg::word_t wdata);
        mm_ram_pkg::word_t unused;
        bus_access(addr, 1'b1, be, wdata, unused);
        model_write(addr, be, wdata);
    endtask

    task automatic read_check(input mm_ram_pkg::word_t addr);
        mm_ram_pkg::word_t rdata;
        mm_ram_pkg::word_t exp;
        exp = model_read(addr);
        bus_access(addr, 1'b0, 4'hf, '0, rdata);
        if (rdata !== exp)
            fail_value("data_rdata_o", rdata, exp);
    endtask

    // --------------------
    // instruction bus
    task automatic fetch_check(input mm_ram_pkg::word_t addr);
        int                 cycles;
        logic [INSTR_W-1:0] exp;
        exp = model_fetch(addr);
        if (instr_gnt_o !== 1'b0)
            fail_value("instr_gnt_o idle", instr_gnt_o, 0);
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        @(posedge clk_i);
        if (instr_gnt_o !== 1'b1)
            fail_value("instr_gnt_o", instr_gnt_o, 1);
        @(negedge clk_i);
        instr_req_i = 1'b0;
        cycles      = 1;
        while (instr_rvalid_o !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (instr_rvalid_o !== 1'b1)
            fail_text("timeout waiting for instr_rvalid_o");
        else if (cycles != 1)
            fail_value("instr_rvalid_o latency", cycles, 1);
        else if (instr_rdata_o !== exp)
            fail_value("instr_rdata_o", instr_rdata_o, exp);
    endtask

    // --------------------
    // main sequence
    initial begin
        int                   errs;
        int                   cycles;
        int                   d;
        int                   p;
        logic                 busy;
        logic                 prev;
        logic                 exp;
        mm_ram_pkg::word_t    addr;
        mm_ram_pkg::word_t    off;
        mm_ram_pkg::word_t    code;
        mm_ram_pkg::word_t    count;
        mm_ram_pkg::irq_vec_t mask;
        mm_ram_pkg::irq_id_t  id;
        mm_ram_pkg::dbg_cmd_t cmd;
        mm_ram_pkg::dbg_cmd_t other;

        void'($urandom(33373));
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        model_irq      = '0;
        model_dbg      = 1'b0;
        rst_ni         = 1'b0;
        dm_halt_addr_i = 32'h1a11_0000;
        instr_req_i    = 1'b0;
        instr_addr_i   = '0;
        data_req_i     = 1'b0;
        data_i         = '0;
        irq_ack_i      = 1'b0;
        irq_id_i       = '0;
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;

        // test 1 fills a region then does random writes and reads
        errs = errors;
        for (int i = 0; i < FILL_WORDS; i++) begin
            addr = i * 4;
            write_word(addr, 4'hf, {addr[15:0], ~addr[15:0]});
        end
        for (int i = 0; i < 32; i++) begin
            addr = ($urandom % FILL_WORDS) * 4;
            write_word(addr, mm_ram_pkg::be_t'($urandom), $urandom);
        end
        for (int i = 0; i < 32; i++) begin
            read_check(($urandom % FILL_WORDS) * 4);
        end
        @(negedge clk_i);
        if (data_rvalid_o !== 1'b0)
            fail_value("data_rvalid_o idle", data_rvalid_o, 0);
        finish_test("ram random access", errs);

        // test 2 does wide fetches inside the filled region
        errs = errors;
        for (int i = 0; i < 16; i++) begin
            fetch_check(($urandom % (FILL_WORDS - 4)) * 4);
        end
        @(negedge clk_i);
        if (instr_rvalid_o !== 1'b0)
            fail_value("instr_rvalid_o idle", instr_rvalid_o, 0);
        finish_test("instruction fetch", errs);

        // test 3 covers the debug window remap both ways and unmapped reads
        errs = errors;
        dm_halt_addr_i = 32'h0100_0000 | ($urandom & 32'h00ff_fffc);
        for (int i = 0; i < 8; i++) begin
            off = $urandom & 32'h3ff0;
            for (int j = 0; j < 4; j++) begin
                write_word(dm_halt_addr_i + off + j * 4, 4'hf, $urandom);
            end
            read_check(DBG_LOW + off + ($urandom % 4) * 4);
            fetch_check(dm_halt_addr_i + off);
            // write on the low side and read through the window
            off = $urandom & 32'h3ffc;
            write_word(DBG_LOW + off, 4'hf, $urandom);
            read_check(dm_halt_addr_i + off);
        end
        for (int i = 0; i < 4; i++) begin
            addr = 32'h0800_0000 | ($urandom & 32'h00ff_fffc);
            write_word(addr, 4'hf, $urandom);
            read_check(addr);
        end
        finish_test("debug window remap", errs);

        // test 4 writes status codes and exit values
        errs = errors;
        for (int i = 0; i < 6; i++) begin
            case (i % 3)
                0: code = mm_ram_pkg::TEST_PASS_CODE;
                1: code = mm_ram_pkg::TEST_FAIL_CODE;
                default: begin
                    code = $urandom | 32'h8000_0000;
                end
            endcase
            write_word(mm_ram_pkg::ADDR_TEST_STATUS, 4'hf, code);
            if (tests_passed_o !== (code == mm_ram_pkg::TEST_PASS_CODE))
                fail_value("tests_passed_o", tests_passed_o, code == mm_ram_pkg::TEST_PASS_CODE);
            if (tests_failed_o !== (code == mm_ram_pkg::TEST_FAIL_CODE))
                fail_value("tests_failed_o", tests_failed_o, code == mm_ram_pkg::TEST_FAIL_CODE);
            @(negedge clk_i);
            if (tests_passed_o !== 1'b0)
                fail_value("tests_passed_o after pulse", tests_passed_o, 0);
            if (tests_failed_o !== 1'b0)
                fail_value("tests_failed_o after pulse", tests_failed_o, 0);
            code = $urandom;
            write_word(mm_ram_pkg::ADDR_EXIT, 4'hf, code);
            if (exit_valid_o !== 1'b1)
                fail_value("exit_valid_o", exit_valid_o, 1);
            if (exit_value_o !== code)
                fail_value("exit_value_o", exit_value_o, code);
            @(negedge clk_i);
            if (exit_valid_o !== 1'b0)
                fail_value("exit_valid_o", exit_valid_o, 0);
            if (exit_value_o !== code)
                fail_value("exit_value_o hold", exit_value_o, code);
        end
        finish_test("test status", errs);

        // test 5 checks the timer fire cycle and per-bit acknowledge
        errs = errors;
        for (int i = 0; i < 6; i++) begin
            // mask must differ from the current vector to see the fire
            mask = $urandom | 32'h1;
            if (mask == model_irq)
                mask = mask ^ 32'h8000_0000;
            count = 1 + $urandom % 24;
            write_word(mm_ram_pkg::ADDR_TIMER_MASK, 4'hf, mask);
            write_word(mm_ram_pkg::ADDR_TIMER_COUNT, 4'hf, count);
            cycles = 0;
            while (irq_o !== mask && cycles < count + WAIT_LIMIT) begin
                @(negedge clk_i);
                cycles++;
            end
            if (irq_o !== mask)
                fail_text("timeout waiting for irq_o to take the mask");
            else if (cycles != count)
                fail_value("irq_o fire cycle", cycles, count);
            model_irq = mask;
            for (int j = 0; j < 4; j++) begin
                id        = $urandom;
                irq_ack_i = 1'b1;
                irq_id_i  = id;
                @(negedge clk_i);
                irq_ack_i       = 1'b0;
                model_irq[id]   = 1'b0;
                if (irq_o !== model_irq)
                    fail_value("irq_o after ack", irq_o, model_irq);
            end
        end
        // zero count never fires
        write_word(mm_ram_pkg::ADDR_TIMER_MASK, 4'hf, ~model_irq);
        write_word(mm_ram_pkg::ADDR_TIMER_COUNT, 4'hf, '0);
        repeat (8) @(negedge clk_i);
        if (irq_o !== model_irq)
            fail_value("irq_o zero count", irq_o, model_irq);
        finish_test("irq timer", errs);

        // test 6 checks debug request level and pulse timing
        errs = errors;
        for (int i = 0; i < 12; i++) begin
            cmd          = mm_ram_pkg::dbg_cmd_t'($urandom);
            cmd.delay    = ($urandom % 4 == 0) ? 15'd0 : 15'(1 + $urandom % 8);
            cmd.duration = ($urandom % 4 == 0) ? 13'd0 : 13'(1 + $urandom % 6);
            d    = (cmd.delay == 0) ? 1 : cmd.delay;
            p    = !cmd.pulse_mode ? 0 : (cmd.duration == 0) ? 1 : cmd.duration;
            // a second command only lands while the first is still running
            busy = (d + p >= 2) && ($urandom % 2 == 1);
            prev = model_dbg;
            exp  = prev;
            write_word(mm_ram_pkg::ADDR_DEBUG_CTRL, 4'hf, cmd);
            for (int k = 0; k < d + p + 3; k++) begin
                if (k < d)
                    exp = prev;
                else if (cmd.pulse_mode && k >= d + p)
                    exp = ~cmd.level_value;
                else
                    exp = cmd.level_value;
                if (debug_req_o !== exp)
                    fail_value("debug_req_o", debug_req_o, exp);
                if (k == 1 && busy) begin
                    other             = cmd;
                    other.level_value = ~cmd.level_value;
                    other.pulse_mode  = 1'b0;
                    other.delay       = 15'd1;
                    write_word(mm_ram_pkg::ADDR_DEBUG_CTRL, 4'hf, other);
                end else begin
                    @(negedge clk_i);
                end
            end
            model_dbg = exp;
        end
        finish_test("debug request", errs);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
mm_ram_pkg.sv
mm_ram_dp_ram.sv
mm_ram_addr_decode.sv
mm_ram_status.sv
mm_ram_irq_timer.sv
mm_ram_debug_req.sv
mm_ram.sv
mm_ram_tb.sv
